// File: hdl/rv_pkg.sv
// rv_pkg: widths, reset vector, opcode fields and shared enums of the rv64 core
package rv_pkg;

    localparam int XLEN       = 64;
    localparam int ILEN       = 32;
    localparam int REG_ADDR_W = 5;

    localparam logic [XLEN-1:0] RESET_PC = '0;  // first fetch at word 0
    localparam logic [XLEN-1:0] PC_STEP  = 4;   // one 32-bit instruction

    // major opcode field, inst[6:0]
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

    localparam logic [ILEN-1:0] EBREAK_INST = 32'h0010_0073;  // the only system op taken

    typedef enum logic [3:0] {
        ALU_ADD = 4'd0,
        ALU_SUB = 4'd1,
        ALU_AND = 4'd2,
        ALU_OR  = 4'd3,
        ALU_XOR = 4'd4,
        ALU_SLT = 4'd5,
        ALU_LUI = 4'd6,
        ALU_BEQ = 4'd7,
        ALU_BNE = 4'd8,
        ALU_JAL = 4'd9,
        ALU_NOP = 4'd15  // unknown encodings and ebreak
    } alu_op_e;

    typedef enum logic {
        CTRL_RUN  = 1'b0,
        CTRL_HALT = 1'b1
    } ctrl_state_e;

endpackage

// File: hdl/if_stage.sv
// fetch stage: program counter, fetch address and the fetch/decode pipeline register
module if_stage (
    input  logic                    clk,
    input  logic                    rst_n_i,
    input  logic                    fetch_en_i,
    input  logic                    flush_i,
    input  logic                    redirect_i,
    input  logic [rv_pkg::XLEN-1:0] next_pc_i,
    output logic [rv_pkg::XLEN-1:0] imem_addr_o,
    input  logic [rv_pkg::ILEN-1:0] imem_data_i,
    output logic [rv_pkg::XLEN-1:0] if_pc_o,
    output logic [rv_pkg::ILEN-1:0] if_inst_o,
    output logic                    if_valid_o
);
    logic [rv_pkg::XLEN-1:0] pc_q;

    assign imem_addr_o = pc_q;  // memory answers in the same cycle

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            pc_q <= rv_pkg::RESET_PC;
        end else if (redirect_i) begin
            pc_q <= next_pc_i;  // target from execute
        end else if (fetch_en_i) begin
            pc_q <= pc_q + rv_pkg::PC_STEP;
        end
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            if_valid_o <= 1'b0;
        end else begin
            if_valid_o <= fetch_en_i && !flush_i;  // wrong-path fetch becomes a bubble
        end
    end

    always_ff @(posedge clk) begin
        if_pc_o   <= pc_q;
        if_inst_o <= imem_data_i;
    end
endmodule

// File: hdl/reg_file.sv
// register file: 31 writable 64-bit registers, x0 reads zero, writes pass through to reads
module reg_file (
    input  logic                          clk,
    input  logic                          rst_n_i,
    input  logic                          wen_i,
    input  logic [rv_pkg::REG_ADDR_W-1:0] waddr_i,
    input  logic [rv_pkg::XLEN-1:0]       wdata_i,
    input  logic [rv_pkg::REG_ADDR_W-1:0] raddr1_i,
    input  logic [rv_pkg::REG_ADDR_W-1:0] raddr2_i,
    output logic [rv_pkg::XLEN-1:0]       rdata1_o,
    output logic [rv_pkg::XLEN-1:0]       rdata2_o
);
    logic [rv_pkg::XLEN-1:0] regs [1:31];  // no storage behind x0

    // read logic of either port
    function automatic logic [rv_pkg::XLEN-1:0] read_port(
        input logic [rv_pkg::REG_ADDR_W-1:0] raddr
    );
        if (raddr == '0) begin
            return '0;
        end
        if (wen_i && (waddr_i == raddr)) begin
            return wdata_i;  // writeback in this cycle wins
        end
        return regs[raddr];
    endfunction

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wen_i && (waddr_i != '0)) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    always_comb begin
        rdata1_o = read_port(raddr1_i);
        rdata2_o = read_port(raddr2_i);
    end
endmodule

// File: hdl/id_stage.sv
// decode stage: field decode, immediates, operand read and the decode/execute register
module id_stage (
    input  logic                          clk,
    input  logic                          rst_n_i,
    input  logic                          flush_i,
    input  logic [rv_pkg::XLEN-1:0]       if_pc_i,
    input  logic [rv_pkg::ILEN-1:0]       if_inst_i,
    input  logic                          if_valid_i,
    input  logic                          wb_wen_i,
    input  logic [rv_pkg::REG_ADDR_W-1:0] wb_waddr_i,
    input  logic [rv_pkg::XLEN-1:0]       wb_wdata_i,
    output logic                          id_valid_o,
    output rv_pkg::alu_op_e               id_alu_op_o,
    output logic [rv_pkg::REG_ADDR_W-1:0] id_rd_o,
    output logic                          id_reg_wen_o,
    output logic [rv_pkg::REG_ADDR_W-1:0] id_rs1_o,
    output logic [rv_pkg::REG_ADDR_W-1:0] id_rs2_o,
    output logic [rv_pkg::XLEN-1:0]       id_rs1_data_o,
    output logic [rv_pkg::XLEN-1:0]       id_rs2_data_o,
    output logic [rv_pkg::XLEN-1:0]       id_imm_o,
    output logic [rv_pkg::XLEN-1:0]       id_pc_o,
    output logic                          id_ebreak_o
);
    logic [6:0]                    opcode;
    logic [2:0]                    funct3;
    logic [6:0]                    funct7;
    logic [rv_pkg::REG_ADDR_W-1:0] rs1_addr;
    logic [rv_pkg::REG_ADDR_W-1:0] rs2_addr;
    logic [rv_pkg::REG_ADDR_W-1:0] rd_addr;
    logic [rv_pkg::XLEN-1:0]       rs1_data;
    logic [rv_pkg::XLEN-1:0]       rs2_data;
    logic [rv_pkg::XLEN-1:0]       imm;
    rv_pkg::alu_op_e               alu_op;
    logic                          reg_wen;
    logic                          use_imm;
    logic                          ebreak;

    assign opcode   = if_inst_i[6:0];
    assign rd_addr  = if_inst_i[11:7];
    assign funct3   = if_inst_i[14:12];
    assign rs1_addr = if_inst_i[19:15];
    assign rs2_addr = if_inst_i[24:20];
    assign funct7   = if_inst_i[31:25];

    reg_file u_reg_file (
        .clk      (clk),
        .rst_n_i  (rst_n_i),
        .wen_i    (wb_wen_i),
        .waddr_i  (wb_waddr_i),
        .wdata_i  (wb_wdata_i),
        .raddr1_i (rs1_addr),
        .raddr2_i (rs2_addr),
        .rdata1_o (rs1_data),
        .rdata2_o (rs2_data)
    );

    always_comb begin
        alu_op  = rv_pkg::ALU_NOP;
        reg_wen = 1'b0;
        use_imm = 1'b0;
        ebreak  = 1'b0;
        imm     = '0;
        case (opcode)
            rv_pkg::OPC_OP: begin
                reg_wen = 1'b1;
                case ({funct7, funct3})
                    {7'h00, 3'b000}: alu_op = rv_pkg::ALU_ADD;
                    {7'h20, 3'b000}: alu_op = rv_pkg::ALU_SUB;
                    {7'h00, 3'b111}: alu_op = rv_pkg::ALU_AND;
                    {7'h00, 3'b110}: alu_op = rv_pkg::ALU_OR;
                    {7'h00, 3'b100}: alu_op = rv_pkg::ALU_XOR;
                    {7'h00, 3'b010}: alu_op = rv_pkg::ALU_SLT;
                    default:         reg_wen = 1'b0;
                endcase
            end
            rv_pkg::OPC_OP_IMM: begin
                imm = {{(rv_pkg::XLEN-12){if_inst_i[31]}}, if_inst_i[31:20]};
                if (funct3 == 3'b000) begin  // addi only
                    alu_op  = rv_pkg::ALU_ADD;
                    reg_wen = 1'b1;
                    use_imm = 1'b1;
                end
            end
            rv_pkg::OPC_LUI: begin
                alu_op  = rv_pkg::ALU_LUI;
                reg_wen = 1'b1;
                imm     = {{(rv_pkg::XLEN-32){if_inst_i[31]}}, if_inst_i[31:12], 12'b0};
            end
            rv_pkg::OPC_BRANCH: begin
                imm = {{(rv_pkg::XLEN-12){if_inst_i[31]}}, if_inst_i[7],
                       if_inst_i[30:25], if_inst_i[11:8], 1'b0};
                if (funct3 == 3'b000) begin
                    alu_op = rv_pkg::ALU_BEQ;
                end else if (funct3 == 3'b001) begin
                    alu_op = rv_pkg::ALU_BNE;
                end
            end
            rv_pkg::OPC_JAL: begin
                alu_op  = rv_pkg::ALU_JAL;
                reg_wen = 1'b1;
                imm     = {{(rv_pkg::XLEN-20){if_inst_i[31]}}, if_inst_i[19:12],
                           if_inst_i[20], if_inst_i[30:21], 1'b0};
            end
            rv_pkg::OPC_SYSTEM: ebreak = (if_inst_i == rv_pkg::EBREAK_INST);
            default: ;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            id_valid_o <= 1'b0;
        end else begin
            id_valid_o <= if_valid_i && !flush_i;
        end
    end

    // addi rides the rs2 data path, with rs2 index 0 so nothing forwards over it
    always_ff @(posedge clk) begin
        id_alu_op_o   <= alu_op;
        id_rd_o       <= rd_addr;
        id_reg_wen_o  <= reg_wen && (rd_addr != '0);  // x0 never written
        id_rs1_o      <= rs1_addr;
        id_rs2_o      <= use_imm ? '0 : rs2_addr;
        id_rs1_data_o <= rs1_data;
        id_rs2_data_o <= use_imm ? imm : rs2_data;
        id_imm_o      <= imm;
        id_pc_o       <= if_pc_i;
        id_ebreak_o   <= ebreak;
    end
endmodule

// File: hdl/ex_stage.sv
// execute stage: operand forwarding, alu, branch resolution and the writeback register
module ex_stage (
    input  logic                          clk,
    input  logic                          rst_n_i,
    input  logic                          id_valid_i,
    input  rv_pkg::alu_op_e               id_alu_op_i,
    input  logic [rv_pkg::REG_ADDR_W-1:0] id_rd_i,
    input  logic                          id_reg_wen_i,
    input  logic [rv_pkg::REG_ADDR_W-1:0] id_rs1_i,
    input  logic [rv_pkg::REG_ADDR_W-1:0] id_rs2_i,
    input  logic [rv_pkg::XLEN-1:0]       id_rs1_data_i,
    input  logic [rv_pkg::XLEN-1:0]       id_rs2_data_i,
    input  logic [rv_pkg::XLEN-1:0]       id_imm_i,
    input  logic [rv_pkg::XLEN-1:0]       id_pc_i,
    input  logic                          id_ebreak_i,
    output logic                          wb_wen_o,
    output logic [rv_pkg::REG_ADDR_W-1:0] wb_waddr_o,
    output logic [rv_pkg::XLEN-1:0]       wb_wdata_o,
    output logic                          wb_valid_o,
    output logic                          ebreak_o,
    output logic                          redirect_o,
    output logic [rv_pkg::XLEN-1:0]       next_pc_o
);
    logic [rv_pkg::XLEN-1:0] op_a;
    logic [rv_pkg::XLEN-1:0] op_b;
    logic [rv_pkg::XLEN-1:0] alu_res;
    logic                    taken;
    logic                    live;

    // nothing behind an ebreak in writeback may take effect
    assign live = id_valid_i && !ebreak_o;

    assign op_a = (wb_wen_o && (id_rs1_i != '0) && (wb_waddr_o == id_rs1_i))
                ? wb_wdata_o : id_rs1_data_i;
    assign op_b = (wb_wen_o && (id_rs2_i != '0) && (wb_waddr_o == id_rs2_i))
                ? wb_wdata_o : id_rs2_data_i;

    always_comb begin
        alu_res = '0;
        taken   = 1'b0;
        case (id_alu_op_i)
            rv_pkg::ALU_ADD: alu_res = op_a + op_b;
            rv_pkg::ALU_SUB: alu_res = op_a - op_b;
            rv_pkg::ALU_AND: alu_res = op_a & op_b;
            rv_pkg::ALU_OR:  alu_res = op_a | op_b;
            rv_pkg::ALU_XOR: alu_res = op_a ^ op_b;
            rv_pkg::ALU_SLT: alu_res = {{(rv_pkg::XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            rv_pkg::ALU_LUI: alu_res = id_imm_i;
            rv_pkg::ALU_BEQ: taken = (op_a == op_b);
            rv_pkg::ALU_BNE: taken = (op_a != op_b);
            rv_pkg::ALU_JAL: begin
                alu_res = id_pc_i + rv_pkg::PC_STEP;  // link
                taken   = 1'b1;
            end
            default: ;
        endcase
    end

    assign redirect_o = live && taken;
    assign next_pc_o  = id_pc_i + id_imm_i;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wb_valid_o <= 1'b0;
            wb_wen_o   <= 1'b0;
            ebreak_o   <= 1'b0;
        end else begin
            wb_valid_o <= live;
            wb_wen_o   <= live && id_reg_wen_i;
            ebreak_o   <= live && id_ebreak_i;
        end
    end

    always_ff @(posedge clk) begin
        wb_waddr_o <= id_rd_i;
        wb_wdata_o <= alu_res;
    end
endmodule

// File: hdl/core_ctrl.sv
// core control: run/halt FSM that drives fetch enable and the pipeline flushes
module core_ctrl (
    input  logic clk,
    input  logic rst_n_i,
    input  logic redirect_i,
    input  logic ebreak_i,
    output logic fetch_en_o,
    output logic flush_o,
    output logic halted_o
);
    rv_pkg::ctrl_state_e state_q;
    rv_pkg::ctrl_state_e state_d;

    always_comb begin
        state_d = state_q;
        case (state_q)
            rv_pkg::CTRL_RUN: begin
                if (ebreak_i) begin
                    state_d = rv_pkg::CTRL_HALT;
                end
            end
            rv_pkg::CTRL_HALT: state_d = rv_pkg::CTRL_HALT;  // left only by reset
            default: state_d = rv_pkg::CTRL_RUN;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q <= rv_pkg::CTRL_RUN;
        end else begin
            state_q <= state_d;
        end
    end

    assign fetch_en_o = (state_q == rv_pkg::CTRL_RUN);
    // halt shows as soon as ebreak reaches writeback
    assign halted_o   = (state_q == rv_pkg::CTRL_HALT) || ebreak_i;
    assign flush_o    = redirect_i || halted_o;  // younger slots are dropped
endmodule

// File: hdl/retire_counter.sv
// retire counter: counts instructions that complete writeback, ebreak included
module retire_counter (
    input  logic                    clk,
    input  logic                    rst_n_i,
    input  logic                    retire_i,
    output logic [rv_pkg::XLEN-1:0] retired_o
);
    localparam logic [rv_pkg::XLEN-1:0] ONE = 1;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            retired_o <= '0;
        end else if (retire_i) begin
            retired_o <= retired_o + ONE;  // one per valid writeback slot
        end
    end
endmodule

// File: hdl/rv_core_top.sv
// rv_core_top: four-stage rv64i subset core with control and retire counter
module rv_core_top (
    input  logic                          clk,
    input  logic                          rst_n_i,
    output logic [rv_pkg::XLEN-1:0]       imem_addr_o,
    input  logic [rv_pkg::ILEN-1:0]       imem_data_i,
    output logic                          wb_wen_o,
    output logic [rv_pkg::REG_ADDR_W-1:0] wb_waddr_o,
    output logic [rv_pkg::XLEN-1:0]       wb_wdata_o,
    output logic                          halted_o,
    output logic [rv_pkg::XLEN-1:0]       retired_o
);
    logic [rv_pkg::XLEN-1:0]       if_pc;
    logic [rv_pkg::ILEN-1:0]       if_inst;
    logic                          if_valid;
    logic                          id_valid;
    rv_pkg::alu_op_e               id_alu_op;
    logic [rv_pkg::REG_ADDR_W-1:0] id_rd;
    logic                          id_reg_wen;
    logic [rv_pkg::REG_ADDR_W-1:0] id_rs1;
    logic [rv_pkg::REG_ADDR_W-1:0] id_rs2;
    logic [rv_pkg::XLEN-1:0]       id_rs1_data;
    logic [rv_pkg::XLEN-1:0]       id_rs2_data;
    logic [rv_pkg::XLEN-1:0]       id_imm;
    logic [rv_pkg::XLEN-1:0]       id_pc;
    logic                          id_ebreak;
    logic                          wb_valid;
    logic                          ebreak;
    logic                          redirect;
    logic [rv_pkg::XLEN-1:0]       next_pc;
    logic                          fetch_en;
    logic                          flush;

    if_stage u_if_stage (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .fetch_en_i  (fetch_en),
        .flush_i     (flush),
        .redirect_i  (redirect),
        .next_pc_i   (next_pc),
        .imem_addr_o (imem_addr_o),
        .imem_data_i (imem_data_i),
        .if_pc_o     (if_pc),
        .if_inst_o   (if_inst),
        .if_valid_o  (if_valid)
    );

    id_stage u_id_stage (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .flush_i       (flush),
        .if_pc_i       (if_pc),
        .if_inst_i     (if_inst),
        .if_valid_i    (if_valid),
        .wb_wen_i      (wb_wen_o),    // register file write port
        .wb_waddr_i    (wb_waddr_o),
        .wb_wdata_i    (wb_wdata_o),
        .id_valid_o    (id_valid),
        .id_alu_op_o   (id_alu_op),
        .id_rd_o       (id_rd),
        .id_reg_wen_o  (id_reg_wen),
        .id_rs1_o      (id_rs1),
        .id_rs2_o      (id_rs2),
        .id_rs1_data_o (id_rs1_data),
        .id_rs2_data_o (id_rs2_data),
        .id_imm_o      (id_imm),
        .id_pc_o       (id_pc),
        .id_ebreak_o   (id_ebreak)
    );

    ex_stage u_ex_stage (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .id_valid_i    (id_valid),
        .id_alu_op_i   (id_alu_op),
        .id_rd_i       (id_rd),
        .id_reg_wen_i  (id_reg_wen),
        .id_rs1_i      (id_rs1),
        .id_rs2_i      (id_rs2),
        .id_rs1_data_i (id_rs1_data),
        .id_rs2_data_i (id_rs2_data),
        .id_imm_i      (id_imm),
        .id_pc_i       (id_pc),
        .id_ebreak_i   (id_ebreak),
        .wb_wen_o      (wb_wen_o),
        .wb_waddr_o    (wb_waddr_o),
        .wb_wdata_o    (wb_wdata_o),
        .wb_valid_o    (wb_valid),
        .ebreak_o      (ebreak),
        .redirect_o    (redirect),
        .next_pc_o     (next_pc)
    );

    core_ctrl u_core_ctrl (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .redirect_i (redirect),
        .ebreak_i   (ebreak),
        .fetch_en_o (fetch_en),
        .flush_o    (flush),
        .halted_o   (halted_o)
    );

    retire_counter u_retire_counter (
        .clk       (clk),
        .rst_n_i   (rst_n_i),
        .retire_i  (wb_valid),
        .retired_o (retired_o)
    );
endmodule

// File: sim/rv_core_properties.sv
// rv_core_properties: halt and redirect rules of the pipeline control, bound into the core
module rv_core_properties (
    input logic clk,
    input logic rst_n_i,
    input logic halted_i,
    input logic redirect_i,
    input logic wen_i
);
    a_halt_holds: assert property (@(posedge clk) disable iff (!rst_n_i)
        halted_i |=> halted_i) else $error("halt indication fell before reset");

    a_no_write: assert property (@(posedge clk) disable iff (!rst_n_i)
        halted_i |-> !wen_i) else $error("register write while halted");

    a_no_redirect: assert property (@(posedge clk) disable iff (!rst_n_i)
        halted_i |-> !redirect_i) else $error("redirect while halted");
endmodule

bind rv_core_top rv_core_properties u_core_props (
    .clk        (clk),
    .rst_n_i    (rst_n_i),
    .halted_i   (halted_o),   // high from the ebreak writeback cycle on
    .redirect_i (redirect),
    .wen_i      (wb_wen_o)
);

// File: sim/tb_rv_core.sv
// tb_rv_core: random program run on the rv64 core, checked against an ISA model
module tb_rv_core;
    localparam int PROG_LEN   = 200;
    localparam int MAX_CYCLES = 3 * PROG_LEN + 20;
    localparam logic [31:0] SEED = 32'hd3b2_cc07;
    localparam int K_ADD    = 0;
    localparam int K_SUB    = 1;
    localparam int K_AND    = 2;
    localparam int K_OR     = 3;
    localparam int K_XOR    = 4;
    localparam int K_SLT    = 5;
    localparam int K_ADDI   = 6;
    localparam int K_LUI    = 7;
    localparam int K_BEQ    = 8;
    localparam int K_BNE    = 9;
    localparam int K_JAL    = 10;
    localparam int K_EBREAK = 11;
    localparam logic [31:0] NOP_INST = {12'h000, 5'd0, 3'b000, 5'd0, rv_pkg::OPC_OP_IMM};

    logic                          clk = 1'b0;
    logic                          rst_n;
    logic [rv_pkg::XLEN-1:0]       imem_addr;
    logic [rv_pkg::XLEN-1:0]       fetch_idx;
    logic [rv_pkg::ILEN-1:0]       imem_data;
    logic                          wb_wen;
    logic [rv_pkg::REG_ADDR_W-1:0] wb_waddr;
    logic [rv_pkg::XLEN-1:0]       wb_wdata;
    logic                          halted;
    logic [rv_pkg::XLEN-1:0]       retired;

    logic [31:0] prog [PROG_LEN];
    int          kind_a [PROG_LEN];
    int          rd_a [PROG_LEN];
    int          rs1_a [PROG_LEN];
    int          rs2_a [PROG_LEN];
    logic [63:0] imm_a [PROG_LEN];  // sign-extended immediate or byte offset
    int unsigned exp_idx [$];
    logic [63:0] exp_data [$];
    int          model_count = 0;
    int          value_errs = 0;
    int          other_errs = 0;
    int          cycles = 0;

    always #2 clk = ~clk;

    assign fetch_idx = imem_addr >> 2;
    assign imem_data = (fetch_idx < PROG_LEN) ? prog[fetch_idx] : NOP_INST;  // nop past the end

    rv_core_top UUT (
        .clk         (clk),
        .rst_n_i     (rst_n),
        .imem_addr_o (imem_addr),
        .imem_data_i (imem_data),
        .wb_wen_o    (wb_wen),
        .wb_waddr_o  (wb_waddr),
        .wb_wdata_o  (wb_wdata),
        .halted_o    (halted),
        .retired_o   (retired)
    );

    function automatic logic [31:0] encode(input int i);
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [63:0] imm;
        rd  = rd_a[i][4:0];
        rs1 = rs1_a[i][4:0];
        rs2 = rs2_a[i][4:0];
        imm = imm_a[i];
        case (kind_a[i])
            K_ADD:  return {7'h00, rs2, rs1, 3'b000, rd, rv_pkg::OPC_OP};
            K_SUB:  return {7'h20, rs2, rs1, 3'b000, rd, rv_pkg::OPC_OP};
            K_AND:  return {7'h00, rs2, rs1, 3'b111, rd, rv_pkg::OPC_OP};
            K_OR:   return {7'h00, rs2, rs1, 3'b110, rd, rv_pkg::OPC_OP};
            K_XOR:  return {7'h00, rs2, rs1, 3'b100, rd, rv_pkg::OPC_OP};
            K_SLT:  return {7'h00, rs2, rs1, 3'b010, rd, rv_pkg::OPC_OP};
            K_ADDI: return {imm[11:0], rs1, 3'b000, rd, rv_pkg::OPC_OP_IMM};
            K_LUI:  return {imm[31:12], rd, rv_pkg::OPC_LUI};
            K_BEQ:  return {imm[12], imm[10:5], rs2, rs1, 3'b000, imm[4:1], imm[11],
                            rv_pkg::OPC_BRANCH};
            K_BNE:  return {imm[12], imm[10:5], rs2, rs1, 3'b001, imm[4:1], imm[11],
                            rv_pkg::OPC_BRANCH};
            K_JAL:  return {imm[20], imm[10:1], imm[11], imm[19:12], rd, rv_pkg::OPC_JAL};
            default: return {12'h001, 5'd0, 3'b000, 5'd0, rv_pkg::OPC_SYSTEM};  // ebreak
        endcase
    endfunction

    task automatic gen_program();
        int          r;
        int          span;
        logic [11:0] i12;
        logic [19:0] u20;
        for (int i = 0; i < PROG_LEN; i++) begin
            r        = $urandom % 14;
            rd_a[i]  = $urandom % 8;  // x0..x7 only
            rs1_a[i] = $urandom % 8;
            rs2_a[i] = $urandom % 8;
            i12      = $urandom;
            u20      = $urandom;
            span     = 1 + $urandom % 6;
            if (i + span > PROG_LEN - 1) begin
                span = PROG_LEN - 1 - i;  // never past the final ebreak
            end
            kind_a[i] = (i == PROG_LEN - 1) ? K_EBREAK : ((r > K_JAL) ? K_ADDI : r);
            case (kind_a[i])
                K_ADDI:              imm_a[i] = {{52{i12[11]}}, i12};
                K_LUI:               imm_a[i] = {{32{u20[19]}}, u20, 12'h000};
                K_BEQ, K_BNE, K_JAL: imm_a[i] = span * 4;
                default:             imm_a[i] = '0;
            endcase
            prog[i] = encode(i);
        end
    endtask

    task automatic run_model();
        logic [63:0] x [8];
        logic [63:0] a;
        logic [63:0] b;
        logic [63:0] res;
        logic        wr;
        int          i;
        int          next;
        for (int j = 0; j < 8; j++) begin
            x[j] = '0;
        end
        i = 0;
        while (i < PROG_LEN) begin
            model_count++;
            a    = x[rs1_a[i]];
            b    = x[rs2_a[i]];
            res  = '0;
            wr   = 1'b1;
            next = i + 1;
            case (kind_a[i])
                K_ADD:  res = a + b;
                K_SUB:  res = a - b;
                K_AND:  res = a & b;
                K_OR:   res = a | b;
                K_XOR:  res = a ^ b;
                K_SLT:  res = ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
                K_ADDI: res = a + imm_a[i];
                K_LUI:  res = imm_a[i];
                K_BEQ, K_BNE: begin
                    wr = 1'b0;
                    if ((a == b) == (kind_a[i] == K_BEQ)) begin
                        next = i + int'(imm_a[i][15:2]);
                    end
                end
                K_JAL: begin
                    res  = (i + 1) * 4;  // link
                    next = i + int'(imm_a[i][15:2]);
                end
                default: begin
                    wr   = 1'b0;
                    next = PROG_LEN;  // ebreak ends the program
                end
            endcase
            if (wr && rd_a[i] != 0) begin
                x[rd_a[i]] = res;
                exp_idx.push_back(rd_a[i]);
                exp_data.push_back(res);
            end
            i = next;
        end
    endtask

    task automatic print_counts();
        $display("errors: %0d value mismatches, %0d other failures", value_errs, other_errs);
    endtask

    // every register write is matched against the model in order
    always @(negedge clk) begin
        if (rst_n && wb_wen) begin
            assert (wb_waddr != '0) else begin
                $display("a write to register x0 appeared at writeback");
                other_errs++;
            end
            assert (exp_idx.size() != 0) else begin
                $display("register write to x%0d when the model expects none", wb_waddr);
                other_errs++;
            end
            if (exp_idx.size() != 0) begin
                assert (wb_waddr == exp_idx[0]) else begin
                    $display("[ERROR] wb_waddr_o expected %h actual %h", exp_idx[0], wb_waddr);
                    value_errs++;
                end
                assert (wb_wdata == exp_data[0]) else begin
                    $display("[ERROR] wb_wdata_o expected %h actual %h", exp_data[0], wb_wdata);
                    value_errs++;
                end
                void'(exp_idx.pop_front());
                void'(exp_data.pop_front());
            end
        end
    end

    always @(posedge clk) begin
        if (rst_n) begin
            cycles = cycles + 1;
            if (cycles >= MAX_CYCLES) begin
                $display("the run did not finish within %0d cycles", MAX_CYCLES);
                other_errs++;
                print_counts();
                $display("Test failed");
                $finish;
            end
        end
    end

    initial begin
        logic [63:0] ret_at_halt;
        void'($urandom(SEED));
        gen_program();
        run_model();
        rst_n = 1'b0;
        repeat (5) @(posedge clk);
        #1 rst_n = 1'b1;
        @(negedge clk);
        assert (imem_addr == rv_pkg::RESET_PC) else begin
            $display("[ERROR] imem_addr_o expected %h actual %h", rv_pkg::RESET_PC, imem_addr);
            value_errs++;
        end
        assert (!wb_wen && !halted) else begin
            $display("wb_wen_o or halted_o is high right after reset");
            other_errs++;
        end
        while (!halted) @(negedge clk);
        assert (exp_idx.size() == 0) else begin
            $display("halt reached with %0d model writes still missing", exp_idx.size());
            other_errs++;
        end
        @(negedge clk);  // ebreak retires on this edge
        assert (retired == model_count) else begin
            $display("[ERROR] retired_o expected %h actual %h", model_count, retired);
            value_errs++;
        end
        ret_at_halt = retired;
        repeat (10) begin
            @(negedge clk);
            assert (halted && !wb_wen) else begin
                $display("halted_o fell or a register write happened after halt");
                other_errs++;
            end
            assert (retired == ret_at_halt) else begin
                $display("[ERROR] retired_o expected %h actual %h", ret_at_halt, retired);
                value_errs++;
            end
        end
        print_counts();
        if (value_errs + other_errs == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end
endmodule

// File: sim.f
hdl/rv_pkg.sv
hdl/if_stage.sv
hdl/reg_file.sv
hdl/id_stage.sv
hdl/ex_stage.sv
hdl/core_ctrl.sv
hdl/retire_counter.sv
hdl/rv_core_top.sv
sim/rv_core_properties.sv
sim/tb_rv_core.sv

// File: Bender.yml
package:
  name: rv_core

sources:
  - hdl/rv_pkg.sv
  - hdl/if_stage.sv
  - hdl/reg_file.sv
  - hdl/id_stage.sv
  - hdl/ex_stage.sv
  - hdl/core_ctrl.sv
  - hdl/retire_counter.sv
  - hdl/rv_core_top.sv
  - target: simulation
    files:
      - sim/rv_core_properties.sv
      - sim/tb_rv_core.sv
